/* tb.f */
design/com_pkg.sv
design/com_cs.sv
design/com_tx.sv
design/com_rx.sv
design/com_buf.sv
design/com_top.sv
tb/tb_com.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f tb.f --top-module tb_com -o sim_tb_com; then
    echo "FAIL: Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_com > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in $LOG"
    exit 1
fi

/* tb/tb_com.sv */
`timescale 1ns/10ps

module tb_com;

    import com_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int STALL_CYCLES = 30;
    localparam int QUIET_CYCLES = 12;

    // Watchdog budget from the frames in all tests and the longest frame
    localparam int FRAME_COUNT = 14;
    localparam int WORD_COUNT  = 6;
    localparam int WATCHDOG_NS = FRAME_COUNT * WORD_COUNT * 40 * CLK_PERIOD;

    localparam logic [3:0] OP_READ = 4'h4;
    localparam logic [3:0] OP_DATA = 4'h5;

    logic        clk;
    logic        rst;
    logic        host_fs_send;
    com_hdr_t    host_hdr;
    logic        host_fd_send;
    logic        fs_com_send;
    logic        fd_com_send;
    com_word_u   com_tx_word;
    logic        fs_com_read;
    logic        fd_com_read;
    com_word_u   com_rx_word;
    logic [7:0]  err_count;

    // Expected buffer contents
    logic [15:0] model_mem [16];
    int          seed;

    com_top uut (
        .clk          (clk),
        .rst          (rst),
        .host_fs_send (host_fs_send),
        .host_hdr     (host_hdr),
        .host_fd_send (host_fd_send),
        .fs_com_send  (fs_com_send),
        .fd_com_send  (fd_com_send),
        .com_tx_word  (com_tx_word),
        .fs_com_read  (fs_com_read),
        .fd_com_read  (fd_com_read),
        .com_rx_word  (com_rx_word),
        .err_count    (err_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [15:0] make_hdr(input logic [3:0] opcode,
                                             input logic [3:0] addr,
                                             input logic [7:0] len);
        return {opcode, addr, len};
    endfunction

    function automatic logic [3:0] wrap_addr(input logic [3:0] base, input int offset);
        return 4'((int'(base) + offset) % 16);
    endfunction

    // ------------------------------------------------------------------------
    // Remote partner
    // ------------------------------------------------------------------------

    task automatic remote_put(input logic [15:0] word);
        com_rx_word.data = word;
        fs_com_read = 1'b1;
        next_cycle();
        while (!fd_com_read) next_cycle();
        fs_com_read = 1'b0;
        while (fd_com_read) next_cycle();
    endtask

    // Holds fd_com_send low for stall cycles once the word is offered
    task automatic remote_get(input int stall, output logic [15:0] word);
        while (!fs_com_send) next_cycle();
        word = com_tx_word.data;
        repeat (stall) begin
            next_cycle();
            expect_equal("fs_com_send", 32'(fs_com_send), 32'd1);
            expect_equal("com_tx_word", 32'(com_tx_word.data), 32'(word));
        end
        fd_com_send = 1'b1;
        next_cycle();
        while (fs_com_send) next_cycle();
        fd_com_send = 1'b0;
    endtask

    task automatic write_frame(input logic [3:0] addr, input logic [7:0] len);
        logic [31:0] r;
        logic [3:0]  idx;
        remote_put(make_hdr(OP_DATA, addr, len));
        for (int i = 0; i < int'(len); i++) begin
            r = $random(seed);
            idx = wrap_addr(addr, i);
            model_mem[idx] = r[15:0];
            remote_put(r[15:0]);
        end
    endtask

    // Word 0 is the header
    // stall_word picks the word that is held back
    task automatic receive_frame(input logic [3:0] addr, input logic [7:0] len,
                                 input int stall_word);
        logic [15:0] word;
        logic [3:0]  idx;
        remote_get((stall_word == 0) ? STALL_CYCLES : 0, word);
        expect_equal("host_fd_send", 32'(host_fd_send), 32'd0);
        expect_equal("com_tx_word", 32'(word), 32'(make_hdr(OP_DATA, addr, len)));
        for (int i = 0; i < int'(len); i++) begin
            idx = wrap_addr(addr, i);
            remote_get((stall_word == i + 1) ? STALL_CYCLES : 0, word);
            expect_equal("host_fd_send", 32'(host_fd_send), 32'd0);
            expect_equal("com_tx_word", 32'(word), 32'(model_mem[idx]));
        end
    endtask

    task automatic read_back(input logic [3:0] addr, input logic [7:0] len,
                             input int stall_word);
        remote_put(make_hdr(OP_READ, addr, len));
        receive_frame(addr, len, stall_word);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        expect_equal("fs_com_send", 32'(fs_com_send), 32'd0);
        expect_equal("fd_com_read", 32'(fd_com_read), 32'd0);
        expect_equal("host_fd_send", 32'(host_fd_send), 32'd0);
        expect_equal("err_count", 32'(err_count), 32'd0);
    endtask

    task automatic test_write_read();
        write_frame(4'd3, 8'd5);
        read_back(4'd3, 8'd5, -1);
    endtask

    task automatic test_wrap();
        write_frame(4'd14, 8'd4);
        read_back(4'd14, 8'd4, -1);
    endtask

    task automatic test_host_send();
        host_hdr.opcode = OP_DATA;
        host_hdr.addr   = 4'd0;
        host_hdr.len    = 8'd3;
        host_fs_send    = 1'b1;
        receive_frame(4'd0, 8'd3, -1);
        while (!host_fd_send) next_cycle();
        // Done stays up while the host still holds its request
        next_cycle();
        expect_equal("host_fd_send", 32'(host_fd_send), 32'd1);
        host_fs_send = 1'b0;
        next_cycle();
        while (host_fd_send) next_cycle();
        // No further frame once the host request is gone
        repeat (QUIET_CYCLES) begin
            next_cycle();
            expect_equal("fs_com_send", 32'(fs_com_send), 32'd0);
        end
    endtask

    task automatic test_bad_opcode();
        remote_put(make_hdr(4'h1, 4'd2, 8'd3));
        remote_put(make_hdr(4'hc, 4'd0, 8'd1));
        expect_equal("err_count", 32'(err_count), 32'd2);
        read_back(4'd3, 8'd5, -1);
    endtask

    task automatic test_back_pressure();
        write_frame(4'd9, 8'd3);
        read_back(4'd9, 8'd3, 2);
        expect_equal("err_count", 32'(err_count), 32'd2);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        host_fs_send = 1'b0;
        host_hdr     = '0;
        fd_com_send  = 1'b0;
        fs_com_read  = 1'b0;
        com_rx_word  = '0;
        seed         = 32'h5fd;
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = 16'h0000;
        end

        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;

        test_reset_state();
        test_write_read();
        test_wrap();
        test_host_send();
        test_bad_opcode();
        test_back_pressure();

        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the link stopped responding before the tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* design/com_top.sv */
`timescale 1ns/10ps

module com_top (
    input  logic               clk,
    input  logic               rst,

    input  logic               host_fs_send,
    input  com_pkg::com_hdr_t  host_hdr,
    output logic               host_fd_send,

    output logic               fs_com_send,
    input  logic               fd_com_send,
    output com_pkg::com_word_u com_tx_word,

    input  logic               fs_com_read,
    output logic               fd_com_read,
    input  com_pkg::com_word_u com_rx_word,

    output logic [7:0]         err_count
);

    import com_pkg::*;

    // Channel handshakes
    logic      fs_send;
    logic      fd_send;
    com_word_u send_word;
    logic      fs_read;
    logic      fd_read;

    // Buffer ports
    buf_req_t  rx_buf_req;
    buf_rsp_t  rx_buf_rsp;
    buf_req_t  tx_buf_req;
    buf_rsp_t  tx_buf_rsp;

    tx_req_t   reply;

    com_cs u_cs (
        .clk         (clk),
        .rst         (rst),
        .fs_send     (fs_send),
        .fd_send     (fd_send),
        .send_word   (send_word),
        .fs_read     (fs_read),
        .fd_read     (fd_read),
        .fs_com_send (fs_com_send),
        .fd_com_send (fd_com_send),
        .com_tx_word (com_tx_word),
        .fs_com_read (fs_com_read),
        .fd_com_read (fd_com_read)
    );

    com_tx u_tx (
        .clk          (clk),
        .rst          (rst),
        .tx_req       (reply),
        .host_fs_send (host_fs_send),
        .host_hdr     (host_hdr),
        .host_fd_send (host_fd_send),
        .fs_send      (fs_send),
        .fd_send      (fd_send),
        .send_word    (send_word),
        .buf_req      (tx_buf_req),
        .buf_rsp      (tx_buf_rsp)
    );

    com_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .fs_read     (fs_read),
        .fd_read     (fd_read),
        .com_rx_word (com_rx_word),
        .buf_req     (rx_buf_req),
        .buf_rsp     (rx_buf_rsp),
        .tx_req      (reply),
        .err_count   (err_count)
    );

    com_buf u_buf (
        .clk    (clk),
        .rst    (rst),
        .rx_req (rx_buf_req),
        .rx_rsp (rx_buf_rsp),
        .tx_req (tx_buf_req),
        .tx_rsp (tx_buf_rsp)
    );

endmodule

/* design/com_buf.sv */
`timescale 1ns/10ps

module com_buf (
    input  logic              clk,
    input  logic              rst,

    input  com_pkg::buf_req_t rx_req,
    output com_pkg::buf_rsp_t rx_rsp,

    input  com_pkg::buf_req_t tx_req,
    output com_pkg::buf_rsp_t tx_rsp
);

    import com_pkg::*;

    logic [15:0] mem [BUF_DEPTH];
    buf_req_t    sel;
    logic [15:0] rdata;

    // -------------------------------------------------------------------------
    // Fixed priority, receiver first
    // -------------------------------------------------------------------------

    always_comb begin
        if (rx_req.en) begin
            sel = rx_req;
        end else begin
            sel = tx_req;
        end
    end

    always_comb begin
        rx_rsp.gnt   = rx_req.en;
        rx_rsp.rdata = rdata;
        tx_rsp.gnt   = tx_req.en && !rx_req.en;
        tx_rsp.rdata = rdata;
    end

    // -------------------------------------------------------------------------
    // Storage
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (sel.en && sel.we) begin
            mem[sel.addr] <= sel.wdata;
        end
    end

    // Read data one cycle after the grant
    always_ff @(posedge clk) begin
        if (sel.en && !sel.we) begin
            rdata <= mem[sel.addr];
        end
    end

endmodule

/* design/com_rx.sv */
`timescale 1ns/10ps

module com_rx (
    input  logic               clk,
    input  logic               rst,

    input  logic               fs_read,
    output logic               fd_read,
    input  com_pkg::com_word_u com_rx_word,

    output com_pkg::buf_req_t  buf_req,
    input  com_pkg::buf_rsp_t  buf_rsp,

    output com_pkg::tx_req_t   tx_req,
    output logic [7:0]         err_count
);

    import com_pkg::*;

    typedef enum logic [1:0] {
        RX_HDR,
        RX_DATA,
        RX_WRITE,
        RX_ACK
    } state_t;

    state_t            state;
    com_hdr_t          hdr;
    logic [BUF_AW-1:0] cur_addr;
    logic [7:0]        remain;

    // Only meaningful while in RX_HDR
    assign hdr = com_rx_word.hdr;

    assign fd_read = (state == RX_ACK);

    // The remote holds its word until fd_com_read, so no copy is kept
    always_comb begin
        buf_req.en    = (state == RX_WRITE);
        buf_req.we    = 1'b1;
        buf_req.addr  = cur_addr;
        buf_req.wdata = com_rx_word.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= RX_HDR;
            cur_addr  <= '0;
            remain    <= '0;
            tx_req    <= '0;
            err_count <= '0;
        end else begin
            tx_req.valid <= 1'b0;
            case (state)
                RX_HDR: begin
                    if (fs_read) begin
                        case (hdr.opcode)
                            COM_DATA: begin
                                cur_addr <= hdr.addr;
                                remain   <= hdr.len;
                            end
                            COM_READ: begin
                                tx_req.valid <= 1'b1;
                                tx_req.hdr   <= hdr;
                            end
                            default: begin
                                if (err_count != 8'hff) begin
                                    err_count <= err_count + 8'd1;
                                end
                            end
                        endcase
                        state <= RX_ACK;
                    end
                end
                RX_DATA: begin
                    if (fs_read) begin
                        state <= RX_WRITE;
                    end
                end
                RX_WRITE: begin
                    if (buf_rsp.gnt) begin
                        cur_addr <= cur_addr + BUF_AW'(1);
                        remain   <= remain - 8'd1;
                        state    <= RX_ACK;
                    end
                end
                RX_ACK: begin
                    if (!fs_read) begin
                        if (remain != 8'd0) begin
                            state <= RX_DATA;
                        end else begin
                            state <= RX_HDR;
                        end
                    end
                end
                default: state <= RX_HDR;
            endcase
        end
    end

endmodule

/* design/com_tx.sv */
`timescale 1ns/10ps

module com_tx (
    input  logic               clk,
    input  logic               rst,

    input  com_pkg::tx_req_t   tx_req,

    input  logic               host_fs_send,
    input  com_pkg::com_hdr_t  host_hdr,
    output logic               host_fd_send,

    output logic               fs_send,
    input  logic               fd_send,
    output com_pkg::com_word_u send_word,

    output com_pkg::buf_req_t  buf_req,
    input  com_pkg::buf_rsp_t  buf_rsp
);

    import com_pkg::*;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SEND,
        TX_END,
        TX_FETCH,
        TX_LOAD,
        TX_HOST_DONE
    } state_t;

    state_t            state;
    tx_req_t           pend;
    com_hdr_t          start_hdr;
    logic [BUF_AW-1:0] cur_addr;
    logic [7:0]        remain;
    logic              is_host;

    assign fs_send      = (state == TX_SEND);
    assign host_fd_send = (state == TX_HOST_DONE);

    // A pending reply goes before the host
    assign start_hdr = pend.valid ? pend.hdr : host_hdr;

    always_comb begin
        buf_req.en    = (state == TX_FETCH);
        buf_req.we    = 1'b0;
        buf_req.addr  = cur_addr;
        buf_req.wdata = '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= '0;
        end else if (tx_req.valid) begin
            pend <= tx_req;
        end else if (state == TX_IDLE) begin
            pend.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            cur_addr <= '0;
            remain   <= '0;
            is_host  <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pend.valid || host_fs_send) begin
                        cur_addr <= start_hdr.addr;
                        remain   <= start_hdr.len;
                        is_host  <= !pend.valid;
                        state    <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (fd_send) begin
                        state <= TX_END;
                    end
                end
                TX_END: begin
                    if (!fd_send) begin
                        if (remain != 8'd0) begin
                            state <= TX_FETCH;
                        end else if (is_host) begin
                            state <= TX_HOST_DONE;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                TX_FETCH: begin
                    if (buf_rsp.gnt) begin
                        cur_addr <= cur_addr + BUF_AW'(1);
                        remain   <= remain - 8'd1;
                        state    <= TX_LOAD;
                    end
                end
                TX_LOAD: state <= TX_SEND;
                TX_HOST_DONE: begin
                    if (!host_fs_send) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Header built as hdr, payload loaded as raw data
    always_ff @(posedge clk) begin
        if (state == TX_IDLE) begin
            send_word.hdr.opcode <= COM_DATA;
            send_word.hdr.addr   <= start_hdr.addr;
            send_word.hdr.len    <= start_hdr.len;
        end else if (state == TX_LOAD) begin
            send_word.data <= buf_rsp.rdata;
        end
    end

endmodule

/* design/com_cs.sv */
`timescale 1ns/10ps

module com_cs (
    input  logic               clk,
    input  logic               rst,

    input  logic               fs_send,
    output logic               fd_send,
    input  com_pkg::com_word_u send_word,
    output logic               fs_read,
    input  logic               fd_read,

    output logic               fs_com_send,
    input  logic               fd_com_send,
    output com_pkg::com_word_u com_tx_word,
    input  logic               fs_com_read,
    output logic               fd_com_read
);

    import com_pkg::*;

    typedef enum logic [3:0] {
        MAIN_IDLE,
        MAIN_WAIT,
        SEND_IDLE,
        SEND_WORK,
        SEND_WAIT,
        SEND_DONE,
        READ_WAIT,
        READ_DONE
    } state_t;

    state_t     state;
    state_t     next_state;
    logic [7:0] num;
    logic       lat_done;
    logic       accept_send;

    assign fs_com_send = (state == SEND_WAIT);
    assign fd_send     = (state == SEND_DONE);
    assign fs_read     = (state == READ_WAIT);
    assign fd_com_read = (state == READ_DONE);

    // Remote read wins over a local send
    assign accept_send = (state == MAIN_WAIT) && fs_send && !fs_com_read;

    assign lat_done = (int'(num) + 1 >= COM_LATENCY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Latency counter, held once the spacing is met
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (state != SEND_WORK) begin
            num <= '0;
        end else if (!lat_done) begin
            num <= num + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_send) begin
            com_tx_word <= send_word;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE: next_state = MAIN_WAIT;
            MAIN_WAIT: begin
                if (fs_com_read) begin
                    next_state = READ_WAIT;
                end else if (fs_send) begin
                    next_state = SEND_IDLE;
                end
            end

            SEND_IDLE: next_state = SEND_WORK;
            SEND_WORK: begin
                // Previous word must be fully released by the remote
                if (lat_done && !fd_com_send) begin
                    next_state = SEND_WAIT;
                end
            end
            SEND_WAIT: begin
                if (fd_com_send) begin
                    next_state = SEND_DONE;
                end
            end
            SEND_DONE: begin
                if (!fs_send) begin
                    next_state = MAIN_WAIT;
                end
            end

            READ_WAIT: begin
                if (fd_read) begin
                    next_state = READ_DONE;
                end
            end
            READ_DONE: begin
                if (!fs_com_read && !fd_read) begin
                    next_state = MAIN_WAIT;
                end
            end

            default: next_state = MAIN_IDLE;
        endcase
    end

endmodule

/* design/com_pkg.sv */
package com_pkg;

    // Frame opcodes
    localparam logic [3:0] COM_READ = 4'h4;
    localparam logic [3:0] COM_DATA = 4'h5;

    // Cycles between an accepted send and the port strobe
    localparam int COM_LATENCY = 4;

    localparam int BUF_DEPTH = 16;
    localparam int BUF_AW    = 4;

    // -------------------------------------------------------------------------
    // Frame words
    // -------------------------------------------------------------------------

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] addr;
        logic [7:0] len;
    } com_hdr_t;

    // Same 16 bits, header view or raw data view
    typedef union packed {
        com_hdr_t    hdr;
        logic [15:0] data;
    } com_word_u;

    // -------------------------------------------------------------------------
    // Buffer port and reply request
    // -------------------------------------------------------------------------

    typedef struct packed {
        logic              en;
        logic              we;
        logic [BUF_AW-1:0] addr;
        logic [15:0]       wdata;
    } buf_req_t;

    typedef struct packed {
        logic        gnt;
        logic [15:0] rdata;
    } buf_rsp_t;

    // One-cycle pulse from receiver to transmitter
    typedef struct packed {
        logic     valid;
        com_hdr_t hdr;
    } tx_req_t;

endpackage
